// File: filelist.f
src/trx_pkg.sv
src/up_axi.sv
src/trx_if.sv
src/trx_rx.sv
src/trx_tx.sv
src/trx_core.sv
tests/trx_checker.sv
tests/trx_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the transceiver testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module trx_tb -f filelist.f -o trx_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/trx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: src/trx_core.sv
// transceiver top: axi-lite bridge, device framing, rx/tx channels and the register return path
`timescale 1ns/100ps

module trx_core import trx_pkg::*; (
  input  logic               up_clk,
  input  logic               up_rstn,

  // axi-lite slave
  input  logic               up_axi_awvalid,
  input  logic [AXI_AW-1:0]  up_axi_awaddr,
  output logic               up_axi_awready,
  input  logic               up_axi_wvalid,
  input  logic [UP_DW-1:0]   up_axi_wdata,
  output logic               up_axi_wready,
  output logic               up_axi_bvalid,
  output logic [1:0]         up_axi_bresp,
  input  logic               up_axi_bready,
  input  logic               up_axi_arvalid,
  input  logic [AXI_AW-1:0]  up_axi_araddr,
  output logic               up_axi_arready,
  output logic               up_axi_rvalid,
  output logic [1:0]         up_axi_rresp,
  output logic [UP_DW-1:0]   up_axi_rdata,
  input  logic               up_axi_rready,

  // receive
  input  logic               adc_rx_valid,
  input  logic [FRAME_W-1:0] adc_rx_data,
  output logic adc_enable_i0, adc_enable_q0, adc_enable_i1, adc_enable_q1,
  output logic adc_valid_i0, adc_valid_q0, adc_valid_i1, adc_valid_q1,
  output logic [SMP_W-1:0] adc_data_i0, adc_data_q0, adc_data_i1, adc_data_q1,
  input  logic               adc_dovf,

  // transmit
  input  logic               dac_tx_ready,
  output logic               dac_tx_valid,
  output logic [FRAME_W-1:0] dac_tx_data,
  output logic dac_enable_i0, dac_enable_q0, dac_enable_i1, dac_enable_q1,
  output logic dac_valid_i0, dac_valid_q0, dac_valid_i1, dac_valid_q1,
  input  logic [SMP_W-1:0] dac_data_i0, dac_data_q0, dac_data_i1, dac_data_q1,
  input  logic               dac_dunf
);

  // processor bus
  logic               up_wreq;
  logic [UP_AW-1:0]   up_waddr;
  logic [UP_DW-1:0]   up_wdata;
  logic               up_rreq;
  logic [UP_AW-1:0]   up_raddr;
  logic               up_wack;
  logic               up_rack;
  logic [UP_DW-1:0]   up_rdata;
  logic               up_wack_rx;
  logic               up_rack_rx;
  logic [UP_DW-1:0]   up_rdata_rx;
  logic               up_wack_tx;
  logic               up_rack_tx;
  logic [UP_DW-1:0]   up_rdata_tx;

  // framing to channel blocks
  logic               adc_valid;
  logic [FRAME_W-1:0] adc_data;
  logic               dac_valid;
  logic [FRAME_W-1:0] dac_data;

  // slaves return zero outside their window, so an OR is enough
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= up_wack_rx | up_wack_tx;
      up_rack  <= up_rack_rx | up_rack_tx;
      up_rdata <= up_rdata_rx | up_rdata_tx;
    end
  end

  up_axi i_up_axi (.*);

  trx_if i_if (.*);

  trx_rx i_rx (
    .*,
    .up_wack  (up_wack_rx),
    .up_rack  (up_rack_rx),
    .up_rdata (up_rdata_rx));

  trx_tx i_tx (
    .*,
    .up_wack  (up_wack_tx),
    .up_rack  (up_rack_tx),
    .up_rdata (up_rdata_tx));

endmodule

// File: src/trx_if.sv
// device framing: byte-swaps receive frames into samples, packs transmit samples into frames
`timescale 1ns/100ps

module trx_if import trx_pkg::*; (
  input  logic               up_clk,
  input  logic               up_rstn,

  // device side receive, dma side samples out
  input  logic               adc_rx_valid,
  input  logic [FRAME_W-1:0] adc_rx_data,
  output logic               adc_valid,
  output logic [FRAME_W-1:0] adc_data,

  // dma side samples in, device side transmit
  input  logic               dac_valid,
  input  logic [FRAME_W-1:0] dac_data,
  output logic               dac_tx_valid,
  output logic [FRAME_W-1:0] dac_tx_data
);

  // exchange the two bytes of every sample, sample k at bits 16k+15:16k
  function automatic logic [FRAME_W-1:0] swap_frame(input logic [FRAME_W-1:0] frame);
    logic [FRAME_W-1:0] swapped;
    for (int k = 0; k < NUM_CH; k++) begin
      swapped[k*SMP_W +: SMP_W] = {frame[k*SMP_W +: SMP_W/2],
                                   frame[k*SMP_W+SMP_W/2 +: SMP_W/2]};
    end
    return swapped;
  endfunction

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      adc_valid    <= 1'b0;
      dac_tx_valid <= 1'b0;
    end else begin
      adc_valid    <= adc_rx_valid;
      dac_tx_valid <= dac_valid;
    end
  end

  always_ff @(posedge up_clk) begin
    adc_data    <= swap_frame(adc_rx_data);
    dac_tx_data <= swap_frame(dac_data);
  end

endmodule

// File: src/trx_pkg.sv
// trx package: bus widths, register map, field positions and shared enums
package trx_pkg;

  // **************************************************************************
  // widths

  localparam int UP_AW   = 14;
  localparam int UP_DW   = 32;
  localparam int AXI_AW  = 32;
  localparam int SMP_W   = 16;
  localparam int NUM_CH  = 4;
  localparam int FRAME_W = NUM_CH * SMP_W;

  // each register window spans 2**WIN_W words
  localparam int WIN_W = 4;

  // **************************************************************************
  // register map, word addresses

  localparam logic [UP_AW-1:0] RX_BASE        = 14'h010;
  localparam logic [UP_AW-1:0] REG_RX_CTRL    = 14'h010;
  localparam logic [UP_AW-1:0] REG_RX_STATUS  = 14'h011;
  localparam logic [UP_AW-1:0] TX_BASE        = 14'h020;
  localparam logic [UP_AW-1:0] REG_TX_CTRL    = 14'h020;
  localparam logic [UP_AW-1:0] REG_TX_PATTERN = 14'h021;
  localparam logic [UP_AW-1:0] REG_TX_STATUS  = 14'h022;

  // field positions, enables always sit in bits NUM_CH-1:0
  localparam int RX_FMT_BIT  = 4;
  localparam int TX_DSEL_LSB = 4;
  localparam int STS_BIT     = 0;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WRESP,
    READ,
    RRESP
  } up_axi_state_t;

  // reserved code behaves as zero
  typedef enum logic [1:0] {
    DSEL_DMA     = 2'd0,
    DSEL_PATTERN = 2'd1,
    DSEL_ZERO    = 2'd2,
    DSEL_RSVD    = 2'd3
  } tx_dsel_t;

endpackage

// File: src/trx_rx.sv
// receive channel: control/status registers, format conversion and per-channel valid
`timescale 1ns/100ps

module trx_rx import trx_pkg::*; (
  input  logic               up_clk,
  input  logic               up_rstn,

  // framed samples from the device interface
  input  logic               adc_valid,
  input  logic [FRAME_W-1:0] adc_data,
  input  logic               adc_dovf,

  // dma side channels
  output logic adc_enable_i0, adc_enable_q0, adc_enable_i1, adc_enable_q1,
  output logic adc_valid_i0, adc_valid_q0, adc_valid_i1, adc_valid_q1,
  output logic [SMP_W-1:0] adc_data_i0, adc_data_q0, adc_data_i1, adc_data_q1,

  // processor bus
  input  logic               up_wreq,
  input  logic [UP_AW-1:0]   up_waddr,
  input  logic [UP_DW-1:0]   up_wdata,
  output logic               up_wack,
  input  logic               up_rreq,
  input  logic [UP_AW-1:0]   up_raddr,
  output logic [UP_DW-1:0]   up_rdata,
  output logic               up_rack
);

  logic [NUM_CH-1:0] rx_enable;
  logic              rx_fmt;
  logic              rx_ovf;
  logic [NUM_CH-1:0] rx_valid;
  logic [SMP_W-1:0]  rx_data [NUM_CH];
  logic              wsel;
  logic              rsel;

  assign wsel = up_wreq && (up_waddr[UP_AW-1:WIN_W] == RX_BASE[UP_AW-1:WIN_W]);
  assign rsel = up_rreq && (up_raddr[UP_AW-1:WIN_W] == RX_BASE[UP_AW-1:WIN_W]);

  // **************************************************************************
  // registers

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rx_enable <= '0;
      rx_fmt    <= 1'b0;
      rx_ovf    <= 1'b0;
      up_wack   <= 1'b0;
      up_rack   <= 1'b0;
      up_rdata  <= '0;
    end else begin
      up_wack <= wsel;
      up_rack <= rsel;
      if (wsel && (up_waddr == REG_RX_CTRL)) begin
        rx_enable <= up_wdata[NUM_CH-1:0];
        rx_fmt    <= up_wdata[RX_FMT_BIT];
      end
      // a new overflow wins over a clear in the same cycle
      if (adc_dovf) begin
        rx_ovf <= 1'b1;
      end else if (wsel && (up_waddr == REG_RX_STATUS) && up_wdata[STS_BIT]) begin
        rx_ovf <= 1'b0;
      end
      up_rdata <= '0;
      if (rsel) begin
        case (up_raddr)
          REG_RX_CTRL:   up_rdata <= UP_DW'({rx_fmt, rx_enable});
          REG_RX_STATUS: up_rdata <= UP_DW'(rx_ovf) << STS_BIT;
          default:       up_rdata <= '0;
        endcase
      end
    end
  end

  // **************************************************************************
  // datapath, offset binary to two's complement is an msb flip

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      rx_valid <= '0;
    end else begin
      rx_valid <= {NUM_CH{adc_valid}} & rx_enable;
    end
  end

  always_ff @(posedge up_clk) begin
    if (adc_valid) begin
      for (int k = 0; k < NUM_CH; k++) begin
        rx_data[k] <= adc_data[k*SMP_W +: SMP_W] ^ {rx_fmt, {(SMP_W-1){1'b0}}};
      end
    end
  end

  assign {adc_enable_q1, adc_enable_i1, adc_enable_q0, adc_enable_i0} = rx_enable;
  assign {adc_valid_q1, adc_valid_i1, adc_valid_q0, adc_valid_i0} = rx_valid;
  assign adc_data_i0 = rx_data[0];
  assign adc_data_q0 = rx_data[1];
  assign adc_data_i1 = rx_data[2];
  assign adc_data_q1 = rx_data[3];

  // acks are single pulses answering a bridge request
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |-> $past(up_wreq) && !$past(up_wack));
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |-> $past(up_rreq) && !$past(up_rack));

endmodule

// File: src/trx_tx.sv
// transmit channel: registers, dma sample requests, data source select and underflow status
`timescale 1ns/100ps

module trx_tx import trx_pkg::*; (
  input  logic               up_clk,
  input  logic               up_rstn,

  // dma side channels
  input  logic               dac_tx_ready,
  output logic dac_enable_i0, dac_enable_q0, dac_enable_i1, dac_enable_q1,
  output logic dac_valid_i0, dac_valid_q0, dac_valid_i1, dac_valid_q1,
  input  logic [SMP_W-1:0] dac_data_i0, dac_data_q0, dac_data_i1, dac_data_q1,
  input  logic               dac_dunf,

  // packed samples to the device interface
  output logic               dac_valid,
  output logic [FRAME_W-1:0] dac_data,

  // processor bus
  input  logic               up_wreq,
  input  logic [UP_AW-1:0]   up_waddr,
  input  logic [UP_DW-1:0]   up_wdata,
  output logic               up_wack,
  input  logic               up_rreq,
  input  logic [UP_AW-1:0]   up_raddr,
  output logic [UP_DW-1:0]   up_rdata,
  output logic               up_rack
);

  logic [NUM_CH-1:0]  tx_enable;
  tx_dsel_t           tx_dsel;
  logic [SMP_W-1:0]   tx_pattern;
  logic               tx_unf;
  logic [SMP_W-1:0]   dma_data [NUM_CH];
  logic [FRAME_W-1:0] tx_frame;
  logic               wsel;
  logic               rsel;

  assign wsel = up_wreq && (up_waddr[UP_AW-1:WIN_W] == TX_BASE[UP_AW-1:WIN_W]);
  assign rsel = up_rreq && (up_raddr[UP_AW-1:WIN_W] == TX_BASE[UP_AW-1:WIN_W]);

  // **************************************************************************
  // registers

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      tx_enable  <= '0;
      tx_dsel    <= DSEL_DMA;
      tx_pattern <= '0;
      tx_unf     <= 1'b0;
      up_wack    <= 1'b0;
      up_rack    <= 1'b0;
      up_rdata   <= '0;
    end else begin
      up_wack <= wsel;
      up_rack <= rsel;
      if (wsel && (up_waddr == REG_TX_CTRL)) begin
        tx_enable <= up_wdata[NUM_CH-1:0];
        tx_dsel   <= tx_dsel_t'(up_wdata[TX_DSEL_LSB +: $bits(tx_dsel_t)]);
      end
      if (wsel && (up_waddr == REG_TX_PATTERN)) begin
        tx_pattern <= up_wdata[SMP_W-1:0];
      end
      if (dac_dunf) begin
        tx_unf <= 1'b1;
      end else if (wsel && (up_waddr == REG_TX_STATUS) && up_wdata[STS_BIT]) begin
        tx_unf <= 1'b0;
      end
      up_rdata <= '0;
      if (rsel) begin
        case (up_raddr)
          REG_TX_CTRL:    up_rdata <= UP_DW'({tx_dsel, tx_enable});
          REG_TX_PATTERN: up_rdata <= UP_DW'(tx_pattern);
          REG_TX_STATUS:  up_rdata <= UP_DW'(tx_unf) << STS_BIT;
          default:        up_rdata <= '0;
        endcase
      end
    end
  end

  // **************************************************************************
  // sample request and source select

  assign {dac_enable_q1, dac_enable_i1, dac_enable_q0, dac_enable_i0} = tx_enable;
  assign {dac_valid_q1, dac_valid_i1, dac_valid_q0, dac_valid_i0} =
    {NUM_CH{dac_tx_ready}} & tx_enable;

  assign dma_data[0] = dac_data_i0;
  assign dma_data[1] = dac_data_q0;
  assign dma_data[2] = dac_data_i1;
  assign dma_data[3] = dac_data_q1;

  // disabled channels send zero
  always_comb begin
    for (int k = 0; k < NUM_CH; k++) begin
      tx_frame[k*SMP_W +: SMP_W] = '0;
      if (tx_enable[k]) begin
        case (tx_dsel)
          DSEL_DMA:              tx_frame[k*SMP_W +: SMP_W] = dma_data[k];
          DSEL_PATTERN:          tx_frame[k*SMP_W +: SMP_W] = tx_pattern;
          DSEL_ZERO, DSEL_RSVD:  tx_frame[k*SMP_W +: SMP_W] = '0;
          default:               tx_frame[k*SMP_W +: SMP_W] = '0;
        endcase
      end
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      dac_valid <= 1'b0;
    end else begin
      dac_valid <= dac_tx_ready;
    end
  end

  always_ff @(posedge up_clk) begin
    dac_data <= tx_frame;
  end

endmodule

// File: src/up_axi.sv
// AXI-lite slave turning AXI transfers into single-cycle processor bus requests
`timescale 1ns/100ps

module up_axi import trx_pkg::*; (
  input  logic              up_clk,
  input  logic              up_rstn,

  // axi-lite slave
  input  logic              up_axi_awvalid,
  input  logic [AXI_AW-1:0] up_axi_awaddr,
  output logic              up_axi_awready,
  input  logic              up_axi_wvalid,
  input  logic [UP_DW-1:0]  up_axi_wdata,
  output logic              up_axi_wready,
  output logic              up_axi_bvalid,
  output logic [1:0]        up_axi_bresp,
  input  logic              up_axi_bready,
  input  logic              up_axi_arvalid,
  input  logic [AXI_AW-1:0] up_axi_araddr,
  output logic              up_axi_arready,
  output logic              up_axi_rvalid,
  output logic [1:0]        up_axi_rresp,
  output logic [UP_DW-1:0]  up_axi_rdata,
  input  logic              up_axi_rready,

  // processor bus
  output logic              up_wreq,
  output logic [UP_AW-1:0]  up_waddr,
  output logic [UP_DW-1:0]  up_wdata,
  input  logic              up_wack,
  output logic              up_rreq,
  output logic [UP_AW-1:0]  up_raddr,
  input  logic [UP_DW-1:0]  up_rdata,
  input  logic              up_rack
);

  up_axi_state_t state;
  logic          wr_start;
  logic          rd_start;

  // writes win when both channels arrive together
  assign wr_start = (state == IDLE) && up_axi_awvalid && up_axi_wvalid;
  assign rd_start = (state == IDLE) && up_axi_arvalid && !wr_start;

  assign up_axi_awready = wr_start;
  assign up_axi_wready  = wr_start;
  assign up_axi_arready = rd_start;

  // byte to word address
  assign up_wreq  = wr_start;
  assign up_waddr = up_axi_awaddr[UP_AW+1:2];
  assign up_wdata = up_axi_wdata;
  assign up_rreq  = rd_start;
  assign up_raddr = up_axi_araddr[UP_AW+1:2];

  assign up_axi_bvalid = (state == WRESP);
  assign up_axi_rvalid = (state == RRESP);
  assign up_axi_bresp  = AXI_RESP_OKAY;
  assign up_axi_rresp  = AXI_RESP_OKAY;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (wr_start) begin
            state <= WRITE;
          end else if (rd_start) begin
            state <= READ;
          end
        end
        WRITE: if (up_wack) state <= WRESP;
        WRESP: if (up_axi_bready) state <= IDLE;
        READ:  if (up_rack) state <= RRESP;
        RRESP: if (up_axi_rready) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // read data held until the master takes it
  always_ff @(posedge up_clk) begin
    if ((state == READ) && up_rack) begin
      up_axi_rdata <= up_rdata;
    end
  end

  // response channels never overlap
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(up_axi_bvalid && up_axi_rvalid));

  // under back-pressure the response holds and no new request goes out
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_axi_bvalid && !up_axi_bready) |=> up_axi_bvalid && !(up_wreq || up_rreq));
  assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_axi_rvalid && !up_axi_rready) |=> up_axi_rvalid && $stable(up_axi_rdata)
      && !(up_wreq || up_rreq));

endmodule

// File: tests/trx_checker.sv
// checker that models the transceiver registers and sample paths and compares each clock
`timescale 1ns/100ps

module trx_checker import trx_pkg::*; (
  input  logic               up_clk,
  input  logic               up_rstn,
  input  logic               up_axi_awvalid,
  input  logic [AXI_AW-1:0]  up_axi_awaddr,
  input  logic               up_axi_awready,
  input  logic               up_axi_wvalid,
  input  logic [UP_DW-1:0]   up_axi_wdata,
  input  logic               up_axi_wready,
  input  logic               up_axi_bvalid,
  input  logic [1:0]         up_axi_bresp,
  input  logic               up_axi_bready,
  input  logic               up_axi_arvalid,
  input  logic [AXI_AW-1:0]  up_axi_araddr,
  input  logic               up_axi_arready,
  input  logic               up_axi_rvalid,
  input  logic [1:0]         up_axi_rresp,
  input  logic [UP_DW-1:0]   up_axi_rdata,
  input  logic               up_axi_rready,
  input  logic               adc_rx_valid,
  input  logic [FRAME_W-1:0] adc_rx_data,
  input  logic adc_enable_i0, adc_enable_q0, adc_enable_i1, adc_enable_q1,
  input  logic adc_valid_i0, adc_valid_q0, adc_valid_i1, adc_valid_q1,
  input  logic [SMP_W-1:0] adc_data_i0, adc_data_q0, adc_data_i1, adc_data_q1,
  input  logic               adc_dovf,
  input  logic               dac_tx_ready,
  input  logic               dac_tx_valid,
  input  logic [FRAME_W-1:0] dac_tx_data,
  input  logic dac_enable_i0, dac_enable_q0, dac_enable_i1, dac_enable_q1,
  input  logic dac_valid_i0, dac_valid_q0, dac_valid_i1, dac_valid_q1,
  input  logic [SMP_W-1:0] dac_data_i0, dac_data_q0, dac_data_i1, dac_data_q1,
  input  logic               dac_dunf,
  output int                 value_errs,
  output int                 proto_errs
);

  // register model
  logic [NUM_CH-1:0]  rx_en;
  logic               rx_fmt;
  logic               rx_ovf;
  logic [NUM_CH-1:0]  tx_en;
  logic [1:0]         tx_dsel;
  logic [SMP_W-1:0]   tx_pat;
  logic               tx_unf;

  // expected pipeline stages
  logic               rx_s1_valid;
  logic [FRAME_W-1:0] rx_s1_data;
  logic               rx_s2_valid;
  logic [NUM_CH-1:0]  rx_s2_mask;
  logic [FRAME_W-1:0] rx_s2_data;
  logic               tx_s1_valid;
  logic [FRAME_W-1:0] tx_s1_frame;
  logic               tx_s2_valid;
  logic [FRAME_W-1:0] tx_s2_frame;

  logic               b_held;
  logic               r_held;
  int                 wr_pend;
  logic [UP_DW-1:0]   rd_q [$];

  logic [NUM_CH-1:0]  adc_en_v;
  logic [NUM_CH-1:0]  adc_val_v;
  logic [NUM_CH-1:0]  dac_en_v;
  logic [NUM_CH-1:0]  dac_val_v;
  logic [SMP_W-1:0]   adc_smp [NUM_CH];
  logic [SMP_W-1:0]   dma_smp [NUM_CH];
  string              ch_name [NUM_CH] = '{"i0", "q0", "i1", "q1"};

  assign adc_en_v  = {adc_enable_q1, adc_enable_i1, adc_enable_q0, adc_enable_i0};
  assign adc_val_v = {adc_valid_q1, adc_valid_i1, adc_valid_q0, adc_valid_i0};
  assign dac_en_v  = {dac_enable_q1, dac_enable_i1, dac_enable_q0, dac_enable_i0};
  assign dac_val_v = {dac_valid_q1, dac_valid_i1, dac_valid_q0, dac_valid_i0};
  assign adc_smp[0] = adc_data_i0;
  assign adc_smp[1] = adc_data_q0;
  assign adc_smp[2] = adc_data_i1;
  assign adc_smp[3] = adc_data_q1;
  assign dma_smp[0] = dac_data_i0;
  assign dma_smp[1] = dac_data_q0;
  assign dma_smp[2] = dac_data_i1;
  assign dma_smp[3] = dac_data_q1;

  initial begin
    value_errs = 0;
    proto_errs = 0;
  end

  // the two bytes of a sample trade places between device and dma side
  function automatic logic [SMP_W-1:0] byte_swap(input logic [SMP_W-1:0] s);
    return {s[7:0], s[15:8]};
  endfunction

  function automatic logic [SMP_W-1:0] tx_sample(input int k);
    if (!tx_en[k]) begin
      return '0;
    end
    case (tx_dsel)
      2'd0:    return dma_smp[k];
      2'd1:    return tx_pat;
      default: return '0;
    endcase
  endfunction

  function automatic logic [UP_DW-1:0] reg_read(input logic [UP_AW-1:0] word);
    case (word)
      REG_RX_CTRL:    return {27'd0, rx_fmt, rx_en};
      REG_RX_STATUS:  return {31'd0, rx_ovf};
      REG_TX_CTRL:    return {26'd0, tx_dsel, tx_en};
      REG_TX_PATTERN: return {16'd0, tx_pat};
      REG_TX_STATUS:  return {31'd0, tx_unf};
      default:        return '0;
    endcase
  endfunction

  task automatic reg_write(input logic [UP_AW-1:0] word, input logic [UP_DW-1:0] data);
    case (word)
      REG_RX_CTRL: begin
        rx_en  = data[3:0];
        rx_fmt = data[4];
      end
      REG_RX_STATUS: begin
        if (data[0]) rx_ovf = 1'b0;
      end
      REG_TX_CTRL: begin
        tx_en   = data[3:0];
        tx_dsel = data[5:4];
      end
      REG_TX_PATTERN: tx_pat = data[15:0];
      REG_TX_STATUS: begin
        if (data[0]) tx_unf = 1'b0;
      end
      default: ;
    endcase
  endtask

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s: got %0h, expected %0h", name, got, exp);
      value_errs++;
    end
  endtask

  task automatic protocol_error(input string what);
    $display("protocol error at %0t: %s", $time, what);
    proto_errs++;
  endtask

  // **************************************************************************
  // compare on the rising edge, where every DUT output has settled

  always @(posedge up_clk) begin
    if (!up_rstn) begin
      rx_en       = '0;
      rx_fmt      = 1'b0;
      rx_ovf      = 1'b0;
      tx_en       = '0;
      tx_dsel     = '0;
      tx_pat      = '0;
      tx_unf      = 1'b0;
      rx_s1_valid = 1'b0;
      rx_s2_valid = 1'b0;
      rx_s2_mask  = '0;
      tx_s1_valid = 1'b0;
      tx_s2_valid = 1'b0;
      b_held      = 1'b0;
      r_held      = 1'b0;
      wr_pend     = 0;
      rd_q.delete();
    end else begin
      // axi-lite response channels
      if (up_axi_bvalid && up_axi_rvalid) begin
        protocol_error("bvalid and rvalid are high together");
      end
      if ((up_axi_bvalid || up_axi_rvalid) && (up_axi_awready || up_axi_arready)) begin
        protocol_error("a request was accepted while a response is pending");
      end
      // address and data of a write are taken together
      check_val("up_axi_wready", 64'(up_axi_wready), 64'(up_axi_awready));
      if (b_held && !up_axi_bvalid) protocol_error("bvalid dropped before bready");
      if (r_held && !up_axi_rvalid) protocol_error("rvalid dropped before rready");
      b_held = up_axi_bvalid && !up_axi_bready;
      r_held = up_axi_rvalid && !up_axi_rready;
      if (up_axi_bvalid) begin
        check_val("up_axi_bresp", 64'(up_axi_bresp), 64'd0);
        if (wr_pend == 0) begin
          protocol_error("write response with no write outstanding");
        end else if (up_axi_bready) begin
          wr_pend--;
        end
      end
      if (up_axi_rvalid) begin
        check_val("up_axi_rresp", 64'(up_axi_rresp), 64'd0);
        if (rd_q.size() == 0) begin
          protocol_error("read response with no read outstanding");
        end else begin
          check_val("up_axi_rdata", 64'(up_axi_rdata), 64'(rd_q[0]));
          if (up_axi_rready) rd_q.delete(0);
        end
      end

      // channel outputs
      for (int k = 0; k < NUM_CH; k++) begin
        check_val({"adc_enable_", ch_name[k]}, 64'(adc_en_v[k]), 64'(rx_en[k]));
        check_val({"adc_valid_", ch_name[k]}, 64'(adc_val_v[k]), 64'(rx_s2_mask[k]));
        if (rx_s2_valid) begin
          check_val({"adc_data_", ch_name[k]}, 64'(adc_smp[k]),
                    64'(rx_s2_data[k*SMP_W +: SMP_W]));
        end
        check_val({"dac_enable_", ch_name[k]}, 64'(dac_en_v[k]), 64'(tx_en[k]));
        check_val({"dac_valid_", ch_name[k]}, 64'(dac_val_v[k]),
                  64'(dac_tx_ready && tx_en[k]));
      end
      check_val("dac_tx_valid", 64'(dac_tx_valid), 64'(tx_s2_valid));
      if (tx_s2_valid) check_val("dac_tx_data", dac_tx_data, tx_s2_frame);

      // next expected outputs use the model as it stands before this edge
      rx_s2_valid = rx_s1_valid;
      rx_s2_mask  = {NUM_CH{rx_s1_valid}} & rx_en;
      for (int k = 0; k < NUM_CH; k++) begin
        rx_s2_data[k*SMP_W +: SMP_W] = byte_swap(rx_s1_data[k*SMP_W +: SMP_W])
                                       ^ {rx_fmt, 15'd0};
      end
      rx_s1_valid = adc_rx_valid;
      rx_s1_data  = adc_rx_data;
      tx_s2_valid = tx_s1_valid;
      tx_s2_frame = tx_s1_frame;
      tx_s1_valid = dac_tx_ready;
      for (int k = 0; k < NUM_CH; k++) begin
        tx_s1_frame[k*SMP_W +: SMP_W] = byte_swap(tx_sample(k));
      end

      // read data is taken before this edge's register updates
      if (up_axi_arvalid && up_axi_arready) begin
        rd_q.push_back(reg_read(up_axi_araddr[UP_AW+1:2]));
      end
      if (up_axi_awvalid && up_axi_awready) begin
        wr_pend++;
        reg_write(up_axi_awaddr[UP_AW+1:2], up_axi_wdata);
      end
      // a pulse beats a clear in the same cycle
      if (adc_dovf) rx_ovf = 1'b1;
      if (dac_dunf) tx_unf = 1'b1;
    end
  end

endmodule

// File: tests/trx_tb.sv
// testbench for the transceiver core with random axi-lite and sample traffic
`timescale 1ns/100ps

module trx_tb import trx_pkg::*; ();

  localparam int RESET_CYCLES = 16;
  localparam int OP_CYCLES    = 20;
  localparam int REG_OPS      = 40;
  localparam int ROUNDS       = 6;
  localparam int ROUND_OPS    = 8;
  localparam int ROUND_CYCLES = 120;
  localparam int STATUS_OPS   = 14;
  localparam int DRAIN_CYCLES = 10;
  localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + REG_OPS * OP_CYCLES
    + ROUNDS * (ROUND_OPS * OP_CYCLES + ROUND_CYCLES)
    + STATUS_OPS * OP_CYCLES + DRAIN_CYCLES);

  logic               up_clk;
  logic               up_rstn;
  logic               up_axi_awvalid;
  logic [AXI_AW-1:0]  up_axi_awaddr;
  logic               up_axi_awready;
  logic               up_axi_wvalid;
  logic [UP_DW-1:0]   up_axi_wdata;
  logic               up_axi_wready;
  logic               up_axi_bvalid;
  logic [1:0]         up_axi_bresp;
  logic               up_axi_bready;
  logic               up_axi_arvalid;
  logic [AXI_AW-1:0]  up_axi_araddr;
  logic               up_axi_arready;
  logic               up_axi_rvalid;
  logic [1:0]         up_axi_rresp;
  logic [UP_DW-1:0]   up_axi_rdata;
  logic               up_axi_rready;
  logic               adc_rx_valid;
  logic [FRAME_W-1:0] adc_rx_data;
  logic adc_enable_i0, adc_enable_q0, adc_enable_i1, adc_enable_q1;
  logic adc_valid_i0, adc_valid_q0, adc_valid_i1, adc_valid_q1;
  logic [SMP_W-1:0] adc_data_i0, adc_data_q0, adc_data_i1, adc_data_q1;
  logic               adc_dovf;
  logic               dac_tx_ready;
  logic               dac_tx_valid;
  logic [FRAME_W-1:0] dac_tx_data;
  logic dac_enable_i0, dac_enable_q0, dac_enable_i1, dac_enable_q1;
  logic dac_valid_i0, dac_valid_q0, dac_valid_i1, dac_valid_q1;
  logic [SMP_W-1:0] dac_data_i0, dac_data_q0, dac_data_i1, dac_data_q1;
  logic               dac_dunf;

  logic pulses_on;
  logic ovf_kick;
  logic unf_kick;
  int   value_errs;
  int   proto_errs;
  int   cycle_cnt = 0;

  trx_core trx_core_i (.*);

  trx_checker mon_i (.*);

  initial begin
    up_clk = 1'b0;
    forever #10 up_clk = ~up_clk;
  end

  always @(posedge up_clk) begin
    cycle_cnt++;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // **************************************************************************
  // sample streams, running from reset release to the end

  initial begin
    adc_rx_valid = 1'b0;
    adc_rx_data  = '0;
    adc_dovf     = 1'b0;
    dac_tx_ready = 1'b0;
    dac_data_i0  = '0;
    dac_data_q0  = '0;
    dac_data_i1  = '0;
    dac_data_q1  = '0;
    dac_dunf     = 1'b0;
    forever begin
      @(negedge up_clk);
      if (up_rstn) begin
        adc_rx_valid = ($urandom % 4) != 0;
        adc_rx_data  = {$urandom, $urandom};
        dac_tx_ready = ($urandom % 3) != 0;
        dac_data_i0  = 16'($urandom);
        dac_data_q0  = 16'($urandom);
        dac_data_i1  = 16'($urandom);
        dac_data_q1  = 16'($urandom);
        adc_dovf     = ovf_kick || (pulses_on && (($urandom % 40) == 0));
        dac_dunf     = unf_kick || (pulses_on && (($urandom % 40) == 0));
      end
    end
  end

  // **************************************************************************
  // axi-lite master

  task automatic axi_write(input logic [UP_AW-1:0] word, input logic [UP_DW-1:0] data);
    int hold;
    hold = $urandom_range(0, 7);
    @(negedge up_clk);
    up_axi_awvalid = 1'b1;
    up_axi_awaddr  = {16'd0, word, 2'b00};
    up_axi_wvalid  = 1'b1;
    up_axi_wdata   = data;
    do @(posedge up_clk); while (!up_axi_awready);
    @(negedge up_clk);
    up_axi_awvalid = 1'b0;
    up_axi_wvalid  = 1'b0;
    // response waits under back-pressure for a random span
    do @(posedge up_clk); while (!up_axi_bvalid);
    repeat (hold) @(posedge up_clk);
    @(negedge up_clk);
    up_axi_bready = 1'b1;
    @(negedge up_clk);
    up_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [UP_AW-1:0] word);
    int hold;
    hold = $urandom_range(0, 7);
    @(negedge up_clk);
    up_axi_arvalid = 1'b1;
    up_axi_araddr  = {16'd0, word, 2'b00};
    do @(posedge up_clk); while (!up_axi_arready);
    @(negedge up_clk);
    up_axi_arvalid = 1'b0;
    do @(posedge up_clk); while (!up_axi_rvalid);
    repeat (hold) @(posedge up_clk);
    @(negedge up_clk);
    up_axi_rready = 1'b1;
    @(negedge up_clk);
    up_axi_rready = 1'b0;
  endtask

  function automatic logic [UP_AW-1:0] window_word();
    logic [UP_AW-1:0] base;
    base = (($urandom % 2) == 0) ? RX_BASE : TX_BASE;
    return base + UP_AW'($urandom % 16);
  endfunction

  function automatic logic [UP_AW-1:0] reg_word();
    case ($urandom % 5)
      0:       return REG_RX_CTRL;
      1:       return REG_RX_STATUS;
      2:       return REG_TX_CTRL;
      3:       return REG_TX_PATTERN;
      default: return REG_TX_STATUS;
    endcase
  endfunction

  // one dovf and one dunf pulse, flags change on the rising edge
  task automatic kick_status();
    @(posedge up_clk);
    ovf_kick = 1'b1;
    unf_kick = 1'b1;
    @(posedge up_clk);
    ovf_kick = 1'b0;
    unf_kick = 1'b0;
  endtask

  task automatic status_rw(input logic [UP_DW-1:0] data);
    axi_write(REG_RX_STATUS, data);
    axi_write(REG_TX_STATUS, data);
    axi_read(REG_RX_STATUS);
    axi_read(REG_TX_STATUS);
  endtask

  initial begin
    void'($urandom(32'h4619));
    pulses_on      = 1'b0;
    ovf_kick       = 1'b0;
    unf_kick       = 1'b0;
    up_rstn        = 1'b0;
    up_axi_awvalid = 1'b0;
    up_axi_awaddr  = '0;
    up_axi_wvalid  = 1'b0;
    up_axi_wdata   = '0;
    up_axi_bready  = 1'b0;
    up_axi_arvalid = 1'b0;
    up_axi_araddr  = '0;
    up_axi_rready  = 1'b0;
    repeat (RESET_CYCLES) @(negedge up_clk);
    up_rstn = 1'b1;

    // register readback across both windows, unused words included
    for (int n = 0; n < REG_OPS; n++) begin
      if (($urandom % 2) == 0) begin
        axi_write(reg_word(), $urandom);
      end else begin
        axi_read(window_word());
      end
    end

    // traffic rounds with fresh channel settings
    @(posedge up_clk);
    pulses_on = 1'b1;
    for (int r = 0; r < ROUNDS; r++) begin
      axi_write(REG_RX_CTRL, $urandom % 32);
      axi_write(REG_TX_CTRL, $urandom % 64);
      axi_write(REG_TX_PATTERN, $urandom);
      repeat (ROUND_CYCLES) @(negedge up_clk);
      axi_read(REG_RX_CTRL);
      axi_read(REG_TX_CTRL);
      axi_read(REG_TX_PATTERN);
      axi_read(REG_RX_STATUS);
      axi_read(REG_TX_STATUS);
    end

    // sticky status, set by a pulse and cleared only by writing 1
    @(posedge up_clk);
    pulses_on = 1'b0;
    status_rw(32'd1);
    kick_status();
    axi_read(REG_RX_STATUS);
    axi_read(REG_TX_STATUS);
    status_rw(32'd0);
    status_rw(32'd1);

    repeat (DRAIN_CYCLES) @(negedge up_clk);
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if ((value_errs + proto_errs) == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule
